// File: verilog.f
+incdir+.
photon_pkg.sv
pulse_edge_detect.sv
bcd_gate_counter.sv
count_fifo_writer.sv
count_fifo.sv
photon_counter_top.sv
tb_photon_counter.sv

// File: tb_photon_counter.sv
`timescale 1ns/1ps

`include "photon_consts.svh"

module tb_photon_counter
    import photon_pkg::*;
();

    ////////////////////////////////////////////////////////////////////////////
    // Constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int SEED         = 64319;
    localparam int RESET_CYCLES = 5;
    // Output drive point after each rising edge
    localparam int DRV_DLY      = 2;
    // Scaled mains period in clock cycles
    localparam int SYNC_PERIOD  = 400;
    localparam int HALF         = SYNC_PERIOD / 2;
    // Quiet zone around every sync rise
    localparam int GUARD        = 10;
    // Widest photon high or low phase
    localparam int MAX_WIDTH    = 6;
    // Slack for reading back a full FIFO
    localparam int DRAIN_CYCLES = 100;

    // DUT ports
    logic       clk;
    logic       rst_n;
    logic       en;
    logic       photon_pulse;
    logic       sync_50hz;
    logic       rd_en;
    bcd_count_t rd_data;
    logic       fifo_empty;
    logic       dropped;

    // Expected frames, oldest first
    logic [`PHOTON_WORD_W-1:0] exp_q[$];
    logic [`PHOTON_WORD_W-1:0] exp_word;
    // Reads allowed by the compare process
    logic        reads_on;
    // Windows closed since reads were stalled
    int          stalled_frames;
    int          cycle_cnt;
    int          cycle_limit;
    int unsigned seed_val;

    photon_counter_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .photon_pulse(photon_pulse),
        .sync_50hz   (sync_50hz),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .fifo_empty  (fifo_empty),
        .dropped     (dropped)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Binary pulse count to eight BCD digits, wraps at 10^8
    function automatic logic [`PHOTON_WORD_W-1:0] to_bcd(input int unsigned value);
        logic [`PHOTON_WORD_W-1:0] res;
        int unsigned rem;
        rem = value % 100000000;
        res = '0;
        for (int i = 0; i < `PHOTON_DIGITS; i++) begin
            res[4*i +: 4] = rem % 10;
            rem = rem / 10;
        end
        return res;
    endfunction

    // Cycles a window needs, stretched when pulses run long
    function automatic int window_len(input int n);
        int busy;
        busy = 2 * GUARD + n * 2 * MAX_WIDTH;
        return (busy > SYNC_PERIOD) ? busy : SYNC_PERIOD;
    endfunction

    // One closed window with n pulses
    // While stalled: 16 fill the FIFO, one waits in the writer, rest are lost
    task automatic expect_frame(input int n);
        if (reads_on || stalled_frames < `PHOTON_FIFO_DEPTH + 1) begin
            exp_q.push_back(to_bcd(n));
        end
        if (!reads_on) begin
            stalled_frames++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // Timeout grows with each test, plus half again as margin
    task automatic add_budget(input int cycles);
        cycle_limit = cycle_limit + cycles + cycles / 2;
    endtask

    // Advance n rising edges, then sit at the drive point
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #DRV_DLY;
    endtask

    // Random-width photon pulses, clear of the sync rises
    task automatic send_pulses(input int n);
        int hi;
        int lo;
        step(GUARD);
        for (int i = 0; i < n; i++) begin
            hi = $urandom_range(MAX_WIDTH, 2);
            lo = $urandom_range(MAX_WIDTH, 2);
            photon_pulse = 1'b1;
            step(hi);
            photon_pulse = 1'b0;
            step(lo);
        end
    endtask

    // Sync square wave up to just before the next rise
    // Sync is already high on entry
    task automatic sync_square_wave();
        step(HALF);
        sync_50hz = 1'b0;
        step(HALF - GUARD);
    endtask

    // Full window, closed by the sync rise at its end
    task automatic run_window(input int n);
        add_budget(window_len(n));
        fork
            send_pulses(n);
            sync_square_wave();
        join
        step(GUARD);
        sync_50hz = 1'b1;
        expect_frame(n);
    endtask

    // en low for one sync period, window stays open across it
    task automatic run_enable_gap(input int before_cnt, input int off_cnt,
                                  input int after_cnt);
        add_budget(3 * SYNC_PERIOD);
        fork
            send_pulses(before_cnt);
            sync_square_wave();
        join
        en = 1'b0;
        step(GUARD);
        // Rise while disabled closes nothing
        sync_50hz = 1'b1;
        fork
            send_pulses(off_cnt);
            sync_square_wave();
        join
        en = 1'b1;
        send_pulses(after_cnt);
        step(GUARD);
        sync_50hz = 1'b1;
        expect_frame(before_cnt + after_cnt);
    endtask

    // Wait for all expected frames, then check status outputs
    task automatic drain_fifo(input logic exp_drop);
        add_budget(DRAIN_CYCLES);
        while (exp_q.size() != 0) begin
            step(1);
        end
        step(GUARD);
        assert (fifo_empty) else fail_run("FIFO still holds words after all frames were read");
        if (exp_drop) begin
            assert (dropped) else fail_run("No dropped window was flagged after back-pressure");
        end else begin
            assert (!dropped) else fail_run("Window flagged as dropped without back-pressure");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare and timeout
    ////////////////////////////////////////////////////////////////////////////

    // Check the head, then pop it at the next edge
    always @(posedge clk) begin
        #DRV_DLY;
        if (!rst_n || !reads_on || fifo_empty) begin
            rd_en = 1'b0;
        end else begin
            assert (exp_q.size() > 0) else fail_run("FIFO returned a word no window produced");
            exp_word = exp_q.pop_front();
            assert (rd_data == exp_word) else
                fail_run($sformatf("Mismatch at %0t: rd_data = %h, expected %h",
                                   $time, rd_data, exp_word));
            rd_en = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        assert (cycle_cnt <= cycle_limit) else
            fail_run($sformatf("Timeout: run exceeded %0d cycles", cycle_limit));
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        en             = 1'b1;
        photon_pulse   = 1'b0;
        sync_50hz      = 1'b0;
        rd_en          = 1'b0;
        reads_on       = 1'b1;
        stalled_frames = 0;
        cycle_cnt      = 0;
        cycle_limit    = 200 + RESET_CYCLES;
        seed_val       = $urandom(SEED);
        repeat (RESET_CYCLES) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;

        // First rise closes the empty window since reset
        add_budget(GUARD);
        step(GUARD);
        sync_50hz = 1'b1;
        expect_frame(0);

        // Random counts, in order
        for (int w = 0; w < 6; w++) begin
            run_window($urandom_range(60, 0));
        end
        drain_fifo(1'b0);

        // Empty window and carry into the tens digit
        run_window(0);
        run_window(99);
        drain_fifo(1'b0);

        // Disabled period inside one open window
        run_enable_gap(12, 15, 9);
        drain_fifo(1'b0);

        // Back-pressure with reads stalled for 20 windows
        reads_on       = 1'b0;
        stalled_frames = 0;
        for (int w = 0; w < 20; w++) begin
            run_window($urandom_range(20, 0));
        end
        // Last window closes while the writer still waits on a full FIFO
        add_budget(GUARD);
        step(GUARD);
        reads_on = 1'b1;
        drain_fifo(1'b1);

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: photon_counter_top.sv
`timescale 1ns/1ps

module photon_counter_top
    import photon_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       photon_pulse,
    input  logic       sync_50hz,
    input  logic       rd_en,
    output bcd_count_t rd_data,
    output logic       fifo_empty,
    output logic       dropped
);

    // Edge strobes
    logic       pulse_rise;
    logic       gate_close;
    // Counter to writer
    bcd_count_t count;
    logic       data_update;
    // Writer and FIFO
    logic       wr_fifo;
    bcd_count_t dout;
    logic       fifo_full;

    // Photon input conditioning
    pulse_edge_detect u_photon_edge (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .sig_in(photon_pulse),
        .rise  (pulse_rise),
        .fall  ()
    );

    // Mains sync rise closes the gate window
    pulse_edge_detect u_sync_edge (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .sig_in(sync_50hz),
        .rise  (gate_close),
        .fall  ()
    );

    bcd_gate_counter u_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .pulse_rise (pulse_rise),
        .gate_close (gate_close),
        .count      (count),
        .data_update(data_update)
    );

    count_fifo_writer u_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_update(data_update),
        .count      (count),
        .fifo_full  (fifo_full),
        .wr_fifo    (wr_fifo),
        .dout       (dout),
        .dropped    (dropped)
    );

    count_fifo u_fifo (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr_en  (wr_fifo),
        .wr_data(dout),
        .rd_en  (rd_en),
        .rd_data(rd_data),
        .full   (fifo_full),
        .empty  (fifo_empty)
    );

endmodule

// File: count_fifo.sv
`timescale 1ns/1ps

`include "photon_consts.svh"

module count_fifo
    import photon_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_en,
    input  bcd_count_t wr_data,
    input  logic       rd_en,
    output bcd_count_t rd_data,
    output logic       full,
    output logic       empty
);

    // Raw word storage
    logic [`PHOTON_WORD_W-1:0] mem [`PHOTON_FIFO_DEPTH];

    // Pointers with one wrap bit above the address
    fifo_ptr_t wr_ptr_q;
    fifo_ptr_t rd_ptr_q;

    // Qualified strobes
    logic do_write;
    logic do_read;

    ////////////////////////////////////////////////////////////////////////////
    // Status
    ////////////////////////////////////////////////////////////////////////////

    // Same address and same wrap bit means nothing stored
    assign empty = (wr_ptr_q == rd_ptr_q);

    // Same address but wrap bits differ
    assign full = (wr_ptr_q[`PHOTON_FIFO_AW] != rd_ptr_q[`PHOTON_FIFO_AW]) &&
                  (wr_ptr_q[`PHOTON_FIFO_AW-1:0] == rd_ptr_q[`PHOTON_FIFO_AW-1:0]);

    // Pop on empty is ignored
    assign do_read  = rd_en & ~empty;
    assign do_write = wr_en & ~full;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_write) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_read) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    // Written word becomes the head one cycle later
    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr_q[`PHOTON_FIFO_AW-1:0]] <= wr_data;
        end
    end

    // Fall-through head, valid whenever empty is low
    assign rd_data = mem[rd_ptr_q[`PHOTON_FIFO_AW-1:0]];

endmodule

// File: count_fifo_writer.sv
`timescale 1ns/1ps

module count_fifo_writer
    import photon_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       data_update,
    input  bcd_count_t count,
    input  logic       fifo_full,
    output logic       wr_fifo,
    output bcd_count_t dout,
    output logic       dropped
);

    // Idle, waiting for room, writing
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_WRITE
    } wr_state_t;

    wr_state_t state_q;

    ////////////////////////////////////////////////////////////////////////////
    // Write sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            wr_fifo <= 1'b0;
            dropped <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    // New window result ready
                    if (data_update) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // Hold dout until the FIFO has room
                    if (!fifo_full) begin
                        wr_fifo <= 1'b1;
                        state_q <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    // Write strobe lasts one cycle
                    wr_fifo <= 1'b0;
                    state_q <= ST_IDLE;
                end
                default: begin
                    wr_fifo <= 1'b0;
                    state_q <= ST_IDLE;
                end
            endcase

            // Window closed while still busy is lost
            // Flag stays set until reset
            if (data_update && (state_q != ST_IDLE)) begin
                dropped <= 1'b1;
            end
        end
    end

    // Capture only when accepted in idle
    always_ff @(posedge clk) begin
        if (data_update && (state_q == ST_IDLE)) begin
            dout <= count;
        end
    end

endmodule

// File: bcd_gate_counter.sv
`timescale 1ns/1ps

`include "photon_consts.svh"

module bcd_gate_counter
    import photon_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       pulse_rise,
    input  logic       gate_close,
    output bcd_count_t count,
    output logic       data_update
);

    // Running total of the open window
    bcd_count_t total_q;
    // Running total plus one
    bcd_count_t total_inc;
    // Value latched when the window closes
    bcd_count_t total_next;

    ////////////////////////////////////////////////////////////////////////////
    // Decimal increment
    ////////////////////////////////////////////////////////////////////////////

    // Adds one with a carry rippling digit by digit
    // Each digit rolls from 9 to 0 and carries upward
    // Past 99999999 the whole count wraps to zero
    function automatic bcd_count_t bcd_inc(input bcd_count_t val);
        bcd_count_t res;
        bcd_digit_t dig;
        logic       carry;
        res   = val;
        // Carry in of one at the least significant digit
        carry = 1'b1;
        for (int i = 0; i < `PHOTON_DIGITS; i++) begin
            dig = val[i];
            if (carry) begin
                if (dig == 4'd9) begin
                    // Roll over and pass the carry on
                    res[i] = 4'd0;
                    carry  = 1'b1;
                end else begin
                    // Absorb the carry here
                    res[i] = dig + 4'd1;
                    carry  = 1'b0;
                end
            end
        end
        return res;
    endfunction

    assign total_inc = bcd_inc(total_q);

    // Photon in the closing cycle still belongs to this window
    assign total_next = pulse_rise ? total_inc : total_q;

    ////////////////////////////////////////////////////////////////////////////
    // Window counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            total_q     <= '0;
            data_update <= 1'b0;
        end else begin
            // Update is a single-cycle pulse
            data_update <= 1'b0;
            if (en) begin
                if (gate_close) begin
                    // Window closed, restart from zero
                    total_q     <= '0;
                    data_update <= 1'b1;
                end else if (pulse_rise) begin
                    total_q <= total_inc;
                end
            end
            // Counter frozen while en is low
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Latched window result
    ////////////////////////////////////////////////////////////////////////////

    // Loaded in the same cycle that raises data_update
    always_ff @(posedge clk) begin
        if (en && gate_close) begin
            count <= total_next;
        end
    end

endmodule

// File: pulse_edge_detect.sv
`timescale 1ns/1ps

module pulse_edge_detect (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    input  logic sig_in,
    output logic rise,
    output logic fall
);

    // Two-flop synchronizer stages
    logic sync_q1;
    logic sync_q2;
    // Previous synchronized level
    logic hist_q;

    ////////////////////////////////////////////////////////////////////////////
    // Synchronizer and history
    ////////////////////////////////////////////////////////////////////////////

    // Keeps running while en is low
    // so that re-enabling never sees a stale level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
            hist_q  <= 1'b0;
        end else begin
            sync_q1 <= sig_in;
            sync_q2 <= sync_q1;
            hist_q  <= sync_q2;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Edge strobes
    ////////////////////////////////////////////////////////////////////////////

    // Registered one-cycle strobes, forced low when disabled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rise <= 1'b0;
            fall <= 1'b0;
        end else begin
            // Low to high on the synchronized level
            rise <= en & sync_q2 & ~hist_q;
            // High to low
            fall <= en & ~sync_q2 & hist_q;
        end
    end

endmodule

// File: photon_pkg.sv
// Types shared by the photon counter blocks
package photon_pkg;

`include "photon_consts.svh"

    ////////////////////////////////////////////////////////////////////////////
    // BCD payload
    ////////////////////////////////////////////////////////////////////////////

    // One decimal digit, legal values 0 to 9
    typedef logic [3:0] bcd_digit_t;

    // Full count, digit 0 in the lowest nibble
    typedef bcd_digit_t [`PHOTON_DIGITS-1:0] bcd_count_t;

    ////////////////////////////////////////////////////////////////////////////
    // FIFO bookkeeping
    ////////////////////////////////////////////////////////////////////////////

    // Extra MSB tells a full FIFO from an empty one
    typedef logic [`PHOTON_FIFO_AW:0] fifo_ptr_t;

endpackage

// File: photon_consts.svh
`ifndef PHOTON_CONSTS_SVH
`define PHOTON_CONSTS_SVH

// Sizing shared by the photon counting subsystem

// Decimal digits held by the gate counter
`define PHOTON_DIGITS 8

// One count word, four bits per BCD digit
`define PHOTON_WORD_W 32

// Number of count words the FIFO can hold
// Must stay a power of two for pointer wrap
`define PHOTON_FIFO_DEPTH 16

// Address bits for PHOTON_FIFO_DEPTH entries
`define PHOTON_FIFO_AW 4

`endif
